/* common/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    ////////////////////
    // data widths
    ////////////////////
    typedef logic [7:0]  adc_word_t;        // adc code or dac control word
    typedef logic [62:0] event_t;           // one packed channel event
    typedef logic [7:0]  chip_id_t;
    typedef logic [5:0]  channel_id_t;
    typedef logic [31:0] timestamp_t;       // low 28 bits go into the event
    typedef logic [1:0]  trigger_type_t;
    typedef logic [7:0]  count8_t;          // burst count and reset length
    typedef logic [15:0] hold_delay_t;      // sampling time in cycles

    localparam trigger_type_t TRIG_NATURAL  = 2'd0;
    localparam trigger_type_t TRIG_EXTERNAL = 2'd1;

    localparam adc_word_t SAR_START = 8'h80;    // msb is tested first

    ////////////////////
    // event field layout
    ////////////////////
    localparam int PKT_TYPE_LO    = 0;
    localparam int PKT_TYPE_HI    = 1;
    localparam int CHIP_ID_LO     = 2;
    localparam int CHIP_ID_HI     = 9;
    localparam int CHANNEL_ID_LO  = 10;
    localparam int CHANNEL_ID_HI  = 15;
    localparam int TS_LO          = 16;
    localparam int TS_HI          = 43;
    localparam int ADC_LO         = 48;
    localparam int ADC_HI         = 55;
    localparam int TRIG_LO        = 56;
    localparam int TRIG_HI        = 57;
    localparam int DOWNSTREAM_BIT = 62;     // flags the packet as going downstream

    localparam logic [1:0] PKT_DATA = 2'b01;    // data packet

endpackage

`default_nettype wire

/* hw/sar_logic.sv */
`timescale 1ns/100ps
`default_nettype none

module sar_logic (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 sar_start,      // load mask, clear code
    input  logic                 sar_step,       // decide one bit
    input  logic                 sar_capture,    // publish the finished code
    input  logic                 readout_mode,
    input  logic                 comp,           // high keeps the tested bit
    output pixel_pkg::adc_word_t adc_word,
    output pixel_pkg::adc_word_t dac_word
);

    import pixel_pkg::*;

    adc_word_t sar_mask;    // bit under test
    adc_word_t sar_code;    // working code of the binary search

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sar_mask <= SAR_START;
            sar_code <= '0;
            adc_word <= '0;
        end else begin
            if (sar_start) begin
                sar_mask <= SAR_START;
                sar_code <= '0;
            end else if (sar_step) begin
                if (comp)
                    sar_code <= sar_code | sar_mask;
                sar_mask <= sar_mask >> 1;
            end
            if (sar_capture)
                adc_word <= sar_code;
        end
    end

    // park the dac at midscale while reading out
    assign dac_word = readout_mode ? SAR_START : (sar_code | sar_mask);

endmodule

`default_nettype wire

/* hw/csa_reset_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csa_reset_timer (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               reset_start,
    input  pixel_pkg::count8_t reset_length,    // zero acts as one
    output logic               csa_reset,
    output logic               reset_busy
);

    import pixel_pkg::*;

    count8_t remain;    // cycles left after the current one

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            remain    <= '0;
            csa_reset <= 1'b0;
        end else if (reset_start) begin
            remain    <= (reset_length == 8'd0) ? 8'd0 : reset_length - 8'd1;
            csa_reset <= 1'b1;
        end else if (remain != 8'd0) begin
            remain    <= remain - 8'd1;
        end else begin
            csa_reset <= 1'b0;
        end
    end

    // covers the cycle before csa_reset rises
    assign reset_busy = csa_reset | reset_start;

endmodule

`default_nettype wire

/* hw/event_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module event_builder (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     latch_time,     // start of conversion
    input  logic                     build_event,
    input  pixel_pkg::chip_id_t      chip_id,
    input  pixel_pkg::channel_id_t   channel_id,
    input  pixel_pkg::timestamp_t    timestamp_32b,
    input  pixel_pkg::adc_word_t     adc_word,
    input  pixel_pkg::trigger_type_t trigger_type,
    output pixel_pkg::event_t        event_word
);

    import pixel_pkg::*;

    logic [TS_HI-TS_LO:0] ts_latched;       // low 28 bits of the time stamp
    trigger_type_t        trig_latched;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ts_latched   <= '0;
            trig_latched <= TRIG_NATURAL;
        end else if (latch_time) begin
            ts_latched   <= timestamp_32b[TS_HI-TS_LO:0];
            trig_latched <= trigger_type;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            event_word <= '0;
        end else if (build_event) begin
            event_word                            <= '0;    // spare bits read zero
            event_word[PKT_TYPE_HI:PKT_TYPE_LO]   <= PKT_DATA;
            event_word[CHIP_ID_HI:CHIP_ID_LO]     <= chip_id;
            event_word[CHANNEL_ID_HI:CHANNEL_ID_LO] <= channel_id;
            event_word[TS_HI:TS_LO]               <= ts_latched;
            event_word[ADC_HI:ADC_LO]             <= adc_word;
            event_word[TRIG_HI:TRIG_LO]           <= trig_latched;
            event_word[DOWNSTREAM_BIT]            <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/channel_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      hit,
    input  logic                      external_trigger,
    input  logic                      channel_mask,
    input  logic                      external_trigger_mask,
    input  pixel_pkg::count8_t        adc_burst,
    input  pixel_pkg::hold_delay_t    adc_hold_delay,
    input  pixel_pkg::adc_word_t      digital_threshold,
    input  pixel_pkg::adc_word_t      adc_word,
    input  logic                      reset_busy,         // csa still in reset
    input  logic                      local_fifo_full,
    output logic                      triggered_natural,
    output pixel_pkg::trigger_type_t  trigger_type,       // held for the whole burst
    output logic                      sample,
    output logic                      strobe,
    output logic                      sar_start,
    output logic                      sar_step,
    output logic                      sar_capture,
    output logic                      readout_mode,
    output logic                      latch_time,
    output logic                      build_event,
    output logic                      fifo_write,
    output logic                      reset_start
);

    import pixel_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SAMPLE,
        RESET_CSA,
        CONVERT,
        SAR_DONE,
        REQUEST_READOUT,
        TRANSFER
    } state_t;

    state_t        state;
    state_t        next_state;
    logic          triggered_external;
    logic          triggered_channel;
    trigger_type_t trigger_code;
    hold_delay_t   hold_cnt;            // cycles spent sampling
    logic [2:0]    sar_cnt;             // one count per sar bit
    count8_t       burst_cnt;           // conversions done for this trigger
    logic          last_conv;

    ////////////////////
    // trigger qualification
    ////////////////////
    always_comb begin
        triggered_natural  = hit & ~channel_mask;
        triggered_external = external_trigger & ~external_trigger_mask;
        triggered_channel  = triggered_natural | triggered_external;
        if (triggered_external && !triggered_natural)
            trigger_code = TRIG_EXTERNAL;
        else
            trigger_code = TRIG_NATURAL;
    end

    // zero burst still means one conversion
    assign last_conv = (adc_burst == 8'd0) || (burst_cnt == adc_burst - 8'd1);

    ////////////////////
    // state machine
    ////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE:            if (triggered_channel && !reset_busy) next_state = SAMPLE;
            SAMPLE:          if (hold_cnt >= adc_hold_delay) next_state = RESET_CSA;
            RESET_CSA:       next_state = CONVERT;
            CONVERT:         if (sar_cnt == 3'd7) next_state = SAR_DONE;
            SAR_DONE:        next_state = REQUEST_READOUT;
            REQUEST_READOUT: if (!local_fifo_full) next_state = TRANSFER;  // wait for room
            TRANSFER:        next_state = last_conv ? IDLE : SAMPLE;
            default:         next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= IDLE;
            hold_cnt     <= '0;
            sar_cnt      <= '0;
            burst_cnt    <= '0;
            trigger_type <= TRIG_NATURAL;
            sample       <= 1'b1;       // track the csa while idle
            strobe       <= 1'b0;
            readout_mode <= 1'b0;
        end else begin
            state        <= next_state;
            hold_cnt     <= (state == SAMPLE) ? hold_cnt + 16'd1 : 16'd0;
            sar_cnt      <= (state == CONVERT) ? sar_cnt + 3'd1 : 3'd0;
            if (state == IDLE) begin
                burst_cnt <= '0;
                if (triggered_channel && !reset_busy)
                    trigger_type <= trigger_code;
            end else if (state == TRANSFER) begin
                burst_cnt <= burst_cnt + 8'd1;
            end
            // levels follow the state being entered
            sample       <= next_state inside {IDLE, SAMPLE, SAR_DONE, REQUEST_READOUT,
                                               TRANSFER};
            strobe       <= (next_state == CONVERT);
            readout_mode <= next_state inside {REQUEST_READOUT, TRANSFER};
        end
    end

    ////////////////////
    // datapath strobes
    ////////////////////
    assign sar_start   = (state == RESET_CSA);
    assign latch_time  = (state == RESET_CSA);
    assign sar_step    = (state == CONVERT);
    assign sar_capture = (state == SAR_DONE);
    assign build_event = (state == REQUEST_READOUT) && !local_fifo_full;
    assign fifo_write  = (state == TRANSFER) && (adc_word >= digital_threshold);
    assign reset_start = (state == TRANSFER) && last_conv;    // end of burst

endmodule

`default_nettype wire

/* local_fifo/local_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module local_fifo #(
    parameter int unsigned LOCAL_FIFO_DEPTH = 8     // power of two, 4 or more
) (
    input  logic              clk,
    input  logic              reset_n,
    input  pixel_pkg::event_t data_in,
    input  logic              write_n,      // low pushes data_in
    input  logic              read_n,       // low pops the oldest entry
    output pixel_pkg::event_t data_out,
    output logic              fifo_full,
    output logic              fifo_empty
);

    import pixel_pkg::*;

    localparam int ADDR_W = $clog2(LOCAL_FIFO_DEPTH);
    localparam logic [ADDR_W:0] FULL_COUNT = (ADDR_W + 1)'(LOCAL_FIFO_DEPTH);

    event_t            mem [LOCAL_FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;      // wraps on its own
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;       // entries held
    logic              do_write;
    logic              do_read;

    assign fifo_full  = (count == FULL_COUNT);
    assign fifo_empty = (count == '0);
    assign do_write   = !write_n && !fifo_full;     // drop writes when full
    assign do_read    = !read_n && !fifo_empty;
    assign data_out   = mem[rd_ptr];                // oldest entry always shown

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/channel_top.sv */
`timescale 1ns/100ps
`default_nettype none

module channel_top #(
    parameter int unsigned LOCAL_FIFO_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    hit,                    // discriminator fired
    input  logic                    external_trigger,
    input  logic                    channel_mask,           // high masks the hit
    input  logic                    external_trigger_mask,
    input  pixel_pkg::chip_id_t     chip_id,
    input  pixel_pkg::channel_id_t  channel_id,
    input  pixel_pkg::timestamp_t   timestamp_32b,
    input  pixel_pkg::count8_t      adc_burst,              // conversions per trigger
    input  pixel_pkg::count8_t      reset_length,           // csa reset cycles
    input  pixel_pkg::hold_delay_t  adc_hold_delay,
    input  pixel_pkg::adc_word_t    digital_threshold,      // lowest code written
    input  logic                    comp,                   // sar comparator
    input  logic                    read_local_fifo_n,      // low pops one event
    output pixel_pkg::event_t       channel_event,
    output pixel_pkg::adc_word_t    dac_word,
    output logic                    fifo_empty,
    output logic                    triggered_natural,
    output logic                    csa_reset,
    output logic                    sample,
    output logic                    strobe
);

    import pixel_pkg::*;

    trigger_type_t trigger_type;
    adc_word_t     adc_word;
    event_t        event_word;
    logic          sar_start;
    logic          sar_step;
    logic          sar_capture;
    logic          readout_mode;
    logic          latch_time;
    logic          build_event;
    logic          fifo_write;
    logic          reset_start;
    logic          reset_busy;
    logic          local_fifo_full;

    channel_ctrl u_ctrl (
        .clk                   (clk),
        .reset_n               (reset_n),
        .hit                   (hit),
        .external_trigger      (external_trigger),
        .channel_mask          (channel_mask),
        .external_trigger_mask (external_trigger_mask),
        .adc_burst             (adc_burst),
        .adc_hold_delay        (adc_hold_delay),
        .digital_threshold     (digital_threshold),
        .adc_word              (adc_word),
        .reset_busy            (reset_busy),
        .local_fifo_full       (local_fifo_full),
        .triggered_natural     (triggered_natural),
        .trigger_type          (trigger_type),
        .sample                (sample),
        .strobe                (strobe),
        .sar_start             (sar_start),
        .sar_step              (sar_step),
        .sar_capture           (sar_capture),
        .readout_mode          (readout_mode),
        .latch_time            (latch_time),
        .build_event           (build_event),
        .fifo_write            (fifo_write),
        .reset_start           (reset_start)
    );

    sar_logic u_sar (
        .clk          (clk),
        .reset_n      (reset_n),
        .sar_start    (sar_start),
        .sar_step     (sar_step),
        .sar_capture  (sar_capture),
        .readout_mode (readout_mode),
        .comp         (comp),
        .adc_word     (adc_word),
        .dac_word     (dac_word)
    );

    csa_reset_timer u_reset_timer (
        .clk          (clk),
        .reset_n      (reset_n),
        .reset_start  (reset_start),
        .reset_length (reset_length),
        .csa_reset    (csa_reset),
        .reset_busy   (reset_busy)
    );

    event_builder u_event (
        .clk           (clk),
        .reset_n       (reset_n),
        .latch_time    (latch_time),
        .build_event   (build_event),
        .chip_id       (chip_id),
        .channel_id    (channel_id),
        .timestamp_32b (timestamp_32b),
        .adc_word      (adc_word),
        .trigger_type  (trigger_type),
        .event_word    (event_word)
    );

    local_fifo #(
        .LOCAL_FIFO_DEPTH (LOCAL_FIFO_DEPTH)
    ) u_local_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .data_in    (event_word),
        .write_n    (~fifo_write),          // fifo write is active low
        .read_n     (read_local_fifo_n),
        .data_out   (channel_event),
        .fifo_full  (local_fifo_full),
        .fifo_empty (fifo_empty)
    );

endmodule

`default_nettype wire

/* bench/tb_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_channel;

    import pixel_pkg::*;

    localparam int DEPTH         = 8;
    localparam int CLK_PERIOD    = 20;
    localparam int MAX_HOLD      = 7;
    localparam int MAX_RESET_LEN = 15;
    localparam int MAX_BURST     = 4;
    localparam int BURST_TRIGS   = 4;
    localparam int FIFO_TRIGS    = DEPTH + 2;      // two more than the fifo holds
    localparam int QUIET_CYCLES  = 40;             // longer than one conversion
    localparam int CONV_CYCLES   = MAX_HOLD + 13;
    localparam int TRIG_CYCLES   = MAX_RESET_LEN + 8;
    localparam int N_TRIGS       = 2 + BURST_TRIGS + FIFO_TRIGS;
    localparam int N_CONVS       = 2 + BURST_TRIGS * MAX_BURST + FIFO_TRIGS;
    localparam int WATCHDOG_CYCLES = 20 + N_CONVS * CONV_CYCLES + N_TRIGS * TRIG_CYCLES
                                     + 2 * QUIET_CYCLES + 100;

    logic          clk;
    logic          reset_n;
    logic          hit;
    logic          external_trigger;
    logic          channel_mask;
    logic          external_trigger_mask;
    chip_id_t      chip_id;
    channel_id_t   channel_id;
    timestamp_t    timestamp_32b;
    count8_t       adc_burst;
    count8_t       reset_length;
    hold_delay_t   adc_hold_delay;
    adc_word_t     digital_threshold;
    logic          comp;
    logic          read_local_fifo_n;
    event_t        channel_event;
    adc_word_t     dac_word;
    logic          fifo_empty;
    logic          triggered_natural;
    logic          csa_reset;
    logic          sample;
    logic          strobe;

    adc_word_t     analog_level;       // charge held on the sampling capacitor
    adc_word_t     level_q[$];         // levels for conversions still to come
    event_t        exp_q[$];
    adc_word_t     exp_level_q[$];
    logic [31:0]   rng_state;
    logic          sample_d;
    count8_t       run_len;            // csa_reset cycles seen so far
    count8_t       strobe_len;         // convert cycles seen so far
    count8_t       reset_pulses;
    count8_t       expected_resets;
    count8_t       conv_count;
    count8_t       pops;
    count8_t       pushed;

    channel_top #(
        .LOCAL_FIFO_DEPTH (DEPTH)
    ) UUT (
        .clk                   (clk),
        .reset_n               (reset_n),
        .hit                   (hit),
        .external_trigger      (external_trigger),
        .channel_mask          (channel_mask),
        .external_trigger_mask (external_trigger_mask),
        .chip_id               (chip_id),
        .channel_id            (channel_id),
        .timestamp_32b         (timestamp_32b),
        .adc_burst             (adc_burst),
        .reset_length          (reset_length),
        .adc_hold_delay        (adc_hold_delay),
        .digital_threshold     (digital_threshold),
        .comp                  (comp),
        .read_local_fifo_n     (read_local_fifo_n),
        .channel_event         (channel_event),
        .dac_word              (dac_word),
        .fifo_empty            (fifo_empty),
        .triggered_natural     (triggered_natural),
        .csa_reset             (csa_reset),
        .sample                (sample),
        .strobe                (strobe)
    );

    // comparator fires while the dac is at or below the held level
    assign comp = (dac_word <= analog_level);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];                    // upper bits are the better ones
    endfunction

    function automatic event_t expected_event(chip_id_t chip, channel_id_t chan,
                                              timestamp_t ts, adc_word_t code,
                                              trigger_type_t trig);
        event_t e;
        e         = '0;
        e[1:0]    = 2'b01;                          // data packet
        e[9:2]    = chip;
        e[15:10]  = chan;
        e[43:16]  = ts[27:0];
        e[55:48]  = code;
        e[57:56]  = trig;
        e[62]     = 1'b1;                           // downstream
        return e;
    endfunction

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_event(input string name, input event_t got, input event_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_adc(input string name, input adc_word_t got, input adc_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input count8_t got, input count8_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // new ids, hold time and threshold, settled before the next trigger
    task automatic set_config(input adc_word_t thresh);
        logic [15:0] r;
        r = next_rand();
        chip_id           <= r[7:0];
        channel_id        <= r[13:8];
        r = next_rand();
        adc_hold_delay    <= {13'd0, r[2:0]};
        digital_threshold <= thresh;
        @(posedge clk);
    endtask

    task automatic start_trigger(input logic ext, input count8_t burst, input count8_t rlen);
        int            n;
        int            i;
        logic [15:0]   r;
        timestamp_t    ts;
        adc_word_t     lvl;
        trigger_type_t trig;
        n    = (burst == 8'd0) ? 1 : int'(burst);
        ts   = {next_rand(), next_rand()};
        trig = ext ? 2'd1 : 2'd0;
        for (i = 0; i < n; i++) begin
            r   = next_rand();
            lvl = r[7:0];
            level_q.push_back(lvl);
            if (lvl >= digital_threshold) begin   // below threshold is dropped
                exp_q.push_back(expected_event(chip_id, channel_id, ts, lvl, trig));
                exp_level_q.push_back(lvl);
                pushed = pushed + 8'd1;
            end
        end
        @(posedge clk);
        timestamp_32b    <= ts;
        adc_burst        <= burst;
        reset_length     <= rlen;
        hit              <= 1'b1;
        external_trigger <= ext;
        channel_mask     <= ext;                    // external case masks the hit
        @(posedge clk);
        check_bit("triggered_natural", triggered_natural, !ext);
        hit              <= 1'b0;
        external_trigger <= 1'b0;
        channel_mask     <= 1'b0;
        expected_resets = expected_resets + 8'd1;
    endtask

    // end of burst is the falling csa_reset
    task automatic wait_done(input logic drain);
        while (reset_pulses != expected_resets || (drain && exp_q.size() != 0))
            @(posedge clk);
        @(posedge clk);
    endtask

    ////////////////////
    // monitors
    ////////////////////
    always @(posedge clk) begin
        sample_d <= sample;
        if (reset_n && sample_d && !sample) begin   // hold starts, level is frozen
            conv_count <= conv_count + 8'd1;
            if (level_q.size() != 0)
                analog_level <= level_q.pop_front();
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            if (csa_reset) begin
                run_len <= run_len + 8'd1;
            end else if (run_len != 8'd0) begin
                check_count("csa_reset length", run_len,
                            (reset_length == 8'd0) ? 8'd1 : reset_length);
                run_len      <= 8'd0;
                reset_pulses <= reset_pulses + 8'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            if (strobe) begin
                strobe_len <= strobe_len + 8'd1;
            end else if (strobe_len != 8'd0) begin
                check_count("strobe length", strobe_len, 8'd8);    // one cycle per sar bit
                strobe_len <= 8'd0;
            end
        end
    end

    always @(posedge clk) begin
        if (reset_n && !read_local_fifo_n && !fifo_empty) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: an event was read from the FIFO when none was expected");
                stop_run();
            end else begin
                check_adc("channel_event adc code", channel_event[55:48],
                          exp_level_q.pop_front());
                check_event("channel_event", channel_event, exp_q.pop_front());
                pops <= pops + 8'd1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        count8_t     burst;
        count8_t     rlen;
        count8_t     convs_before;
        logic [15:0] r;
        int          k;
        rng_state             = 32'd65;
        analog_level          = '0;
        sample_d              = 1'b1;
        run_len               = '0;
        strobe_len            = '0;
        reset_pulses          = '0;
        expected_resets       = '0;
        conv_count            = '0;
        pops                  = '0;
        pushed                = '0;
        reset_n               <= 1'b0;
        hit                   <= 1'b0;
        external_trigger      <= 1'b0;
        channel_mask          <= 1'b0;
        external_trigger_mask <= 1'b0;
        chip_id               <= '0;
        channel_id            <= '0;
        timestamp_32b         <= '0;
        adc_burst             <= '0;
        reset_length          <= '0;
        adc_hold_delay        <= '0;
        digital_threshold     <= '0;
        read_local_fifo_n     <= 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(posedge clk);

        check_adc("dac_word", dac_word, 8'h80);
        check_bit("fifo_empty", fifo_empty, 1'b1);
        check_bit("csa_reset", csa_reset, 1'b0);
        check_bit("sample", sample, 1'b1);

        // single natural hit
        set_config(8'h00);
        r = next_rand();
        start_trigger(1'b0, 8'd0, {4'd0, r[3:0]});
        wait_done(1'b1);

        // external trigger, then both sources masked
        set_config(8'h00);
        r = next_rand();
        start_trigger(1'b1, 8'd0, {4'd0, r[3:0]});
        wait_done(1'b1);
        convs_before = conv_count;
        channel_mask          <= 1'b1;
        external_trigger_mask <= 1'b1;
        hit                   <= 1'b1;
        external_trigger      <= 1'b1;
        @(posedge clk);
        check_bit("triggered_natural", triggered_natural, 1'b0);
        hit                   <= 1'b0;
        external_trigger      <= 1'b0;
        repeat (QUIET_CYCLES) @(posedge clk);
        check_count("conversions", conv_count, convs_before);
        check_bit("fifo_empty", fifo_empty, 1'b1);
        check_count("csa reset pulses", reset_pulses, expected_resets);
        channel_mask          <= 1'b0;
        external_trigger_mask <= 1'b0;

        // bursts with a threshold, first one uses zero burst and zero reset length
        for (k = 0; k < BURST_TRIGS; k++) begin
            set_config(8'h40);
            r     = next_rand();
            burst = (k == 0) ? 8'd0 : {6'd0, r[1:0]} + 8'd1;
            rlen  = (k == 0) ? 8'd0 : {4'd0, r[7:4]};
            start_trigger(1'b0, burst, rlen);
            wait_done(1'b1);
        end
        check_count("events popped", pops, pushed);

        // fill the fifo with reading stopped
        set_config(8'h00);
        read_local_fifo_n <= 1'b1;
        for (k = 0; k < DEPTH; k++) begin
            r = next_rand();
            start_trigger(1'b0, 8'd0, {4'd0, r[3:0]});
            wait_done(1'b0);
        end
        start_trigger(1'b0, 8'd0, 8'd2);
        repeat (QUIET_CYCLES) @(posedge clk);
        check_count("csa reset pulses", reset_pulses, expected_resets - 8'd1);
        check_bit("fifo_empty", fifo_empty, 1'b0);
        read_local_fifo_n <= 1'b0;
        wait_done(1'b1);
        start_trigger(1'b0, 8'd0, 8'd1);
        wait_done(1'b1);
        check_count("events popped", pops, pushed);

        if (exp_q.size() == 0 && pops == pushed) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d expected events never left the FIFO", exp_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* project.f */
common/pixel_pkg.sv
hw/sar_logic.sv
hw/csa_reset_timer.sv
hw/event_builder.sv
hw/channel_ctrl.sv
local_fifo/local_fifo.sv
hw/channel_top.sv
bench/tb_channel.sv

/* run.sh */
#!/bin/sh
# compile the channel testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_channel \
    -Mdir obj_dir -o tb_channel_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/tb_channel_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
